// ==== project.f ====
verilog/fetch_pkg.sv
verilog/static_predictor.sv
verilog/redirect_hold.sv
verilog/fetch_queue.sv
verilog/pc_ctrl.sv
verilog/fetch_frontend.sv
tb/fetch_asserts.sv
tb/fetch_checker.sv
tb/tb_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_fetch -o sim_fetch

./obj_dir/sim_fetch +verilator+error+limit+100 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi

// ==== tb/fetch_asserts.sv ====
// Protocol checks on pc_ctrl, bound from the testbench.
// fail_count lets the testbench see failures in its summary.
`timescale 1ns/1ps
`default_nettype none

module fetch_asserts (
    input logic           clk,
    input logic           rst,
    input logic           hold,
    input logic           push,
    input logic           flush,
    input logic           full,
    input fetch_pkg::pc_t pc
);

    int fail_count = 0;

    a_flush_not_push: assert property (@(posedge clk) disable iff (rst) !(flush && push))
        else begin
            $error("flush and push asserted in the same cycle");
            fail_count++;
        end

    a_pc_frozen: assert property (@(posedge clk) disable iff (rst) hold |=> $stable(pc))
        else begin
            $error("pc moved while fetch was held");
            fail_count++;
        end

    a_push_room: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else begin
            $error("push issued into a full queue");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== tb/fetch_checker.sv ====
// Reference model of the fetch front end, stepped on every rising clock edge.
// Outputs are compared just before each edge, against the state after the previous one.
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  fetch_pkg::redirect_t    id_redirect,
    input  fetch_pkg::redirect_t    ex_redirect,
    input  logic [31:0]             instr,
    input  logic                    pop,
    input  fetch_pkg::pc_t          pc,
    input  fetch_pkg::fetch_entry_t head,
    input  logic                    empty,
    input  logic                    full,
    output int                      errors,
    output int                      checks
);

    fetch_pkg::pc_t          m_pc;
    fetch_pkg::redirect_t    m_pend;
    logic                    m_pend_ex;    // stored redirect came from execute
    fetch_pkg::fetch_entry_t m_q [$];

    function automatic logic guess_taken(input logic [31:0] w);
        return (w[6:0] == fetch_pkg::op_jal) || (w[6:0] == fetch_pkg::op_branch && w[31]);
    endfunction

    // offsets rebuilt from the RISC-V J and B immediate layouts
    function automatic fetch_pkg::pc_t guess_next(input fetch_pkg::pc_t cur,
                                                  input logic [31:0] w);
        fetch_pkg::pc_t off;
        if (w[6:0] == fetch_pkg::op_jal) begin
            off = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else if (w[6:0] == fetch_pkg::op_branch && w[31]) begin
            off = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end else begin
            off = 64'd4;
        end
        return cur + off;
    endfunction

    task automatic mismatch(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic compare_outputs();
        checks++;
        if (pc !== m_pc) mismatch($sformatf("pc %h, expected %h", pc, m_pc));
        if (empty !== (m_q.size() == 0)) mismatch($sformatf("empty %b wrong", empty));
        if (full !== (m_q.size() == fetch_pkg::queue_depth)) begin
            mismatch($sformatf("full %b wrong", full));
        end
        if (m_q.size() > 0 && head !== m_q[0]) begin
            mismatch($sformatf("head pc %h instr %h taken %b, expected pc %h instr %h taken %b",
                               head.pc, head.instr, head.pred_taken,
                               m_q[0].pc, m_q[0].instr, m_q[0].pred_taken));
        end
    endtask

    task automatic step_model();
        logic                    hold;
        fetch_pkg::redirect_t    merged;
        logic                    merged_ex;
        logic                    pushed;
        fetch_pkg::fetch_entry_t e;
        hold   = stall || (m_q.size() == fetch_pkg::queue_depth);
        pushed = 1'b0;
        e      = '{pc: m_pc, instr: instr, pred_taken: guess_taken(instr)};
        if (ex_redirect.valid) begin
            merged    = ex_redirect;
            merged_ex = 1'b1;
        end else if (m_pend.valid && m_pend_ex) begin
            merged    = m_pend;
            merged_ex = 1'b1;
        end else if (id_redirect.valid) begin
            merged    = id_redirect;
            merged_ex = 1'b0;
        end else begin
            merged    = m_pend;
            merged_ex = m_pend_ex;
        end
        if (hold) begin
            m_pend    = merged;
            m_pend_ex = merged_ex;
        end else if (merged.valid) begin
            m_pc      = merged.target;
            m_pend    = '0;
            m_pend_ex = 1'b0;
        end else begin
            pushed = 1'b1;
            m_pc   = guess_next(m_pc, instr);
        end
        if (id_redirect.valid || ex_redirect.valid) begin
            m_q.delete();                        // flush beats push and pop
        end else begin
            if (pop && m_q.size() > 0) void'(m_q.pop_front());
            if (pushed) m_q.push_back(e);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            m_pc      = fetch_pkg::reset_pc;
            m_pend    = '0;
            m_pend_ex = 1'b0;
            m_q.delete();
            errors    = 0;
            checks    = 0;
        end else begin
            compare_outputs();
            step_model();
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_fetch.sv ====
// Testbench for the fetch front end. Memory is 64 words from reset_pc, higher addresses alias.
// Rows are applied one per clock, and every test ends with one stall cycle before its report.
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    typedef struct packed {
        logic                 stall;
        fetch_pkg::redirect_t id;
        fetch_pkg::redirect_t ex;
        logic                 pop;
        fetch_pkg::pc_t       exp_pc;   // pc after this row's edge
    } row_t;

    localparam int num_tests = 5;
    localparam int margin    = 20;     // spare cycles for reset and slack

    logic                    clk;
    logic                    rst;
    logic                    stall;
    logic                    pop;
    fetch_pkg::redirect_t    id_redirect;
    fetch_pkg::redirect_t    ex_redirect;
    logic [31:0]             instr;
    fetch_pkg::pc_t          pc;
    fetch_pkg::fetch_entry_t head;
    logic                    empty;
    logic                    full;
    int                      chk_errors;
    int                      chk_checks;
    int                      tb_errors;
    int                      failed_tests;
    logic                    table_ready;

    logic [31:0] mem [64];
    row_t        rows [$];
    int          row_test [$];
    string       test_names [num_tests];

    assign instr = mem[pc[7:2]];       // answers in the same cycle

    initial clk = 1'b0;
    always #10 clk = ~clk;

    fetch_frontend dut0 (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .id_redirect (id_redirect),
        .ex_redirect (ex_redirect),
        .instr       (instr),
        .pop         (pop),
        .pc          (pc),
        .head        (head),
        .empty       (empty),
        .full        (full)
    );

    fetch_checker chk0 (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .id_redirect (id_redirect),
        .ex_redirect (ex_redirect),
        .instr       (instr),
        .pop         (pop),
        .pc          (pc),
        .head        (head),
        .empty       (empty),
        .full        (full),
        .errors      (chk_errors),
        .checks      (chk_checks)
    );

    bind pc_ctrl fetch_asserts u_asserts (
        .clk   (clk),
        .rst   (rst),
        .hold  (hold),
        .push  (push),
        .flush (flush),
        .full  (full),
        .pc    (pc)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_memory();
        logic [31:0] state;
        logic [31:0] word;
        state = 32'h3b88_5773;
        for (int i = 0; i < 64; i++) begin
            state  = next_random(state);
            word   = state ^ (32'h8000_0000 + 32'(i * 4));   // mixed with the word address
            mem[i] = {word[31:7], 7'b0010011};               // OP-IMM filler, never control
        end
        mem[0]  = 32'h0010_0093;     // addi x1, x0, 1
        mem[1]  = 32'h0020_8113;
        mem[2]  = 32'h0031_0193;
        mem[3]  = 32'h0041_8213;
        mem[4]  = 32'h0052_0293;
        mem[5]  = 32'h0062_8313;
        mem[6]  = 32'h0100_00ef;     // jal x1, +16
        mem[7]  = 32'h0073_0393;
        mem[8]  = 32'h0000_0663;     // beq x0, x0, +12 (forward)
        mem[9]  = 32'h0093_8493;
        mem[10] = 32'hfe00_0ce3;     // beq x0, x0, -8 (backward)
    endtask

    // targets and expected pc as byte offsets from reset_pc
    task automatic add_row(input int t, input logic s, input logic iv, input logic [7:0] it,
                           input logic ev, input logic [7:0] et, input logic p,
                           input logic [7:0] e);
        row_t r;
        r.stall  = s;
        r.id     = '{valid: iv, target: fetch_pkg::reset_pc + fetch_pkg::pc_t'(it)};
        r.ex     = '{valid: ev, target: fetch_pkg::reset_pc + fetch_pkg::pc_t'(et)};
        r.pop    = p;
        r.exp_pc = fetch_pkg::reset_pc + fetch_pkg::pc_t'(e);
        rows.push_back(r);
        row_test.push_back(t);
    endtask

    task automatic build_table();
        test_names[0] = "reset_and_sequential";
        test_names[1] = "static_prediction";
        test_names[2] = "back_pressure";
        test_names[3] = "redirect_priority";
        test_names[4] = "redirect_under_stall";
        add_row(0, 0, 0, 8'h00, 0, 8'h00, 0, 8'h04);
        add_row(0, 0, 0, 8'h00, 0, 8'h00, 0, 8'h08);
        add_row(0, 0, 0, 8'h00, 0, 8'h00, 0, 8'h0c);
        add_row(0, 0, 0, 8'h00, 0, 8'h00, 1, 8'h10);
        add_row(0, 0, 0, 8'h00, 0, 8'h00, 1, 8'h14);
        add_row(0, 0, 0, 8'h00, 0, 8'h00, 1, 8'h18);
        add_row(1, 0, 0, 8'h00, 0, 8'h00, 1, 8'h28);   // jal taken
        add_row(1, 0, 0, 8'h00, 0, 8'h00, 1, 8'h20);   // backward branch taken
        add_row(1, 0, 0, 8'h00, 0, 8'h00, 1, 8'h24);   // forward branch falls through
        add_row(1, 0, 0, 8'h00, 0, 8'h00, 1, 8'h28);
        add_row(1, 0, 0, 8'h00, 0, 8'h00, 1, 8'h20);
        add_row(2, 0, 0, 8'h00, 1, 8'h00, 0, 8'h00);   // flush to start empty
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 0, 8'h04);
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 0, 8'h08);
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 0, 8'h0c);
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 0, 8'h10);   // fourth push, now full
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 0, 8'h10);
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 0, 8'h10);
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 1, 8'h10);
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 0, 8'h14);   // exactly one more push
        add_row(2, 0, 0, 8'h00, 0, 8'h00, 0, 8'h14);
        add_row(3, 0, 0, 8'h00, 0, 8'h00, 1, 8'h14);
        add_row(3, 0, 1, 8'h80, 1, 8'h40, 0, 8'h40);   // both at once, ex wins
        add_row(3, 0, 0, 8'h00, 0, 8'h00, 0, 8'h44);
        add_row(3, 0, 0, 8'h00, 0, 8'h00, 0, 8'h48);
        add_row(3, 0, 1, 8'h08, 0, 8'h00, 0, 8'h08);
        add_row(3, 0, 0, 8'h00, 0, 8'h00, 0, 8'h0c);
        add_row(3, 0, 0, 8'h00, 1, 8'h30, 1, 8'h30);   // pop lost to the flush
        add_row(3, 0, 0, 8'h00, 0, 8'h00, 0, 8'h34);
        add_row(4, 1, 1, 8'h60, 0, 8'h00, 0, 8'h34);
        add_row(4, 1, 0, 8'h00, 1, 8'h70, 0, 8'h34);
        add_row(4, 1, 1, 8'h90, 0, 8'h00, 0, 8'h34);   // late id is dropped
        add_row(4, 1, 0, 8'h00, 0, 8'h00, 0, 8'h34);
        add_row(4, 0, 0, 8'h00, 0, 8'h00, 0, 8'h70);
        add_row(4, 0, 0, 8'h00, 0, 8'h00, 0, 8'h74);
    endtask

    task automatic apply_row(input row_t r);
        stall       = r.stall;
        id_redirect = r.id;
        ex_redirect = r.ex;
        pop         = r.pop;
    endtask

    task automatic idle_inputs();
        stall       = 1'b1;      // freezes pc and queue
        id_redirect = '0;
        ex_redirect = '0;
        pop         = 1'b0;
    endtask

    task automatic check_pc(input int i);
        if (pc !== rows[i].exp_pc) begin
            $display("[ERROR] %0t ns: row %0d pc %h, expected %h", $time, i, pc, rows[i].exp_pc);
            tb_errors++;
        end
    endtask

    function automatic int total_errors();
        return tb_errors + chk_errors + dut0.u_ctrl.u_asserts.fail_count;
    endfunction

    task automatic report_test(input int t, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        if (errs == 0) begin
            $display("test %0d %s: passed", t, test_names[t]);
        end else begin
            $display("test %0d %s: failed with %0d errors", t, test_names[t], errs);
            failed_tests++;
        end
    endtask

    initial begin
        int errs_before;
        rst          = 1'b1;
        stall        = 1'b0;
        pop          = 1'b0;
        id_redirect  = '0;
        ex_redirect  = '0;
        tb_errors    = 0;
        failed_tests = 0;
        table_ready  = 1'b0;
        fill_memory();
        build_table();
        table_ready = 1'b1;
        repeat (3) @(negedge clk);
        rst         = 1'b0;
        errs_before = 0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            @(negedge clk);
            check_pc(i);
            if (i == rows.size() - 1 || row_test[i] != row_test[i + 1]) begin
                idle_inputs();
                @(negedge clk);    // checker has now seen the last row's result
                report_test(row_test[i], errs_before);
                errs_before = total_errors();
            end
        end
        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 num_tests, failed_tests, chk_checks, total_errors());
        if (total_errors() == 0 && failed_tests == 0 && chk_checks > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // budget: one cycle per row, a drain cycle per test, reset and margin
    initial begin
        wait (table_ready);
        repeat (rows.size() + 2 * num_tests + margin) @(posedge clk);
        $display("Timeout: the stimulus table did not finish within its cycle budget");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_frontend.sv ====
// Fetch front end top. The memory answers instr for pc in the same cycle.
// Redirects are one-cycle pulses, stall and pop are plain levels and pulses.
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  fetch_pkg::redirect_t       id_redirect,
    input  fetch_pkg::redirect_t       ex_redirect,
    input  logic [fetch_pkg::ilen-1:0] instr,
    input  logic                       pop,
    output fetch_pkg::pc_t             pc,
    output fetch_pkg::fetch_entry_t    head,
    output logic                       empty,
    output logic                       full
);

    fetch_pkg::pc_t          pred_pc;
    logic                    pred_taken;
    fetch_pkg::redirect_t    pending;
    logic                    hold;
    logic                    apply;
    logic                    push;
    logic                    flush;
    fetch_pkg::fetch_entry_t entry;

    static_predictor u_pred (
        .pc         (pc),
        .instr      (instr),
        .pred_pc    (pred_pc),
        .pred_taken (pred_taken)
    );

    redirect_hold u_hold (
        .clk         (clk),
        .rst         (rst),
        .id_redirect (id_redirect),
        .ex_redirect (ex_redirect),
        .hold        (hold),
        .apply       (apply),
        .pending     (pending)
    );

    fetch_queue u_queue (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .entry (entry),
        .pop   (pop),
        .flush (flush),
        .head  (head),
        .empty (empty),
        .full  (full)
    );

    pc_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .full       (full),
        .pending    (pending),
        .pred_pc    (pred_pc),
        .pred_taken (pred_taken),
        .instr      (instr),
        .id_valid   (id_redirect.valid),
        .ex_valid   (ex_redirect.valid),
        .pc         (pc),
        .apply      (apply),
        .push       (push),
        .entry      (entry),
        .flush      (flush),
        .hold       (hold)
    );

endmodule

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
// Shared widths, encodings and bundle types of the fetch front end.
// RV64 style only: no compressed instructions, so every word is 32 bits.
`default_nettype none

package fetch_pkg;

    localparam int xlen        = 64;                 // pc width
    localparam int ilen        = 32;                 // instruction width
    localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = 2;                  // log2 of queue_depth

    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef logic [xlen-1:0] pc_t;

    // one fetched word, read either as a branch or as a jump
    typedef union packed {
        logic [ilen-1:0] raw;
        struct packed {
            logic       imm12;    // sign bit
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm20;    // sign bit
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

    typedef struct packed {
        logic valid;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        pc_t             pc;
        logic [ilen-1:0] instr;
        logic            pred_taken;
    } fetch_entry_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_queue.sv ====
// Circular FIFO of fetched entries, depth from the package (power of two).
// Flush beats push and pop; push when full and pop when empty are dropped.
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  fetch_pkg::fetch_entry_t entry,
    input  logic                    pop,
    input  logic                    flush,
    output fetch_pkg::fetch_entry_t head,
    output logic                    empty,
    output logic                    full
);

    fetch_pkg::fetch_entry_t mem [fetch_pkg::queue_depth];

    logic [fetch_pkg::queue_ptr_w-1:0] rd_ptr;
    logic [fetch_pkg::queue_ptr_w-1:0] wr_ptr;
    logic [fetch_pkg::queue_ptr_w:0]   count;   // one bit wider, holds depth
    logic                              do_push;
    logic                              do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (fetch_pkg::queue_ptr_w+1)'(fetch_pkg::queue_depth));
    assign do_push = push && !full && !flush;
    assign do_pop  = pop && !empty && !flush;
    assign head    = mem[rd_ptr];             // oldest entry

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + fetch_pkg::queue_ptr_w'(1);   // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + fetch_pkg::queue_ptr_w'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !rst) begin
            mem[wr_ptr] <= entry;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pc_ctrl.sv ====
// Owns the pc register and decides each cycle between hold, redirect and fetch.
// A held redirect is taken on the first cycle without stall or full queue.
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       stall,
    input  logic                       full,
    input  fetch_pkg::redirect_t       pending,
    input  fetch_pkg::pc_t             pred_pc,
    input  logic                       pred_taken,
    input  logic [fetch_pkg::ilen-1:0] instr,
    input  logic                       id_valid,
    input  logic                       ex_valid,
    output fetch_pkg::pc_t             pc,
    output logic                       apply,
    output logic                       push,
    output fetch_pkg::fetch_entry_t    entry,
    output logic                       flush,
    output logic                       hold
);

    fetch_pkg::pc_t pc_next;

    // queue back-pressure freezes fetch just like a pipeline stall
    assign hold = stall || full;

    // any arriving redirect kills the words fetched down the old path
    assign flush = id_valid || ex_valid;

    // a free cycle goes to the redirect first, else to a fetch
    assign apply = !hold && pending.valid;
    assign push  = !hold && !pending.valid;

    // word at the current pc, tagged with its own guess
    assign entry = '{
        pc:         pc,
        instr:      instr,
        pred_taken: pred_taken
    };

    always_comb begin
        if (hold) begin
            pc_next = pc;                 // frozen
        end else if (pending.valid) begin
            pc_next = pending.target;     // redirect, nothing pushed
        end else begin
            pc_next = pred_pc;            // static guess, or pc+4
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= fetch_pkg::reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/redirect_hold.sv ====
// Remembers one redirect across a hold; execute wins over decode.
// A decode redirect cannot replace a stored execute redirect.
`timescale 1ns/1ps
`default_nettype none

module redirect_hold (
    input  logic                 clk,
    input  logic                 rst,
    input  fetch_pkg::redirect_t id_redirect,
    input  fetch_pkg::redirect_t ex_redirect,
    input  logic                 hold,
    input  logic                 apply,
    output fetch_pkg::redirect_t pending
);

    logic           saved_valid;
    logic           saved_ex;     // stored one came from execute
    fetch_pkg::pc_t saved_target;
    logic           merged_ex;

    always_comb begin
        if (ex_redirect.valid) begin
            pending   = ex_redirect;
            merged_ex = 1'b1;
        end else if (saved_valid && saved_ex) begin
            pending   = '{valid: 1'b1, target: saved_target};
            merged_ex = 1'b1;
        end else if (id_redirect.valid) begin
            pending   = id_redirect;
            merged_ex = 1'b0;
        end else begin
            pending   = '{valid: saved_valid, target: saved_target};
            merged_ex = saved_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            saved_valid <= 1'b0;
            saved_ex    <= 1'b0;
        end else if (hold) begin
            saved_valid <= pending.valid;
            saved_ex    <= merged_ex;
        end else if (apply) begin
            saved_valid <= 1'b0;      // consumed by the pc
            saved_ex    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hold) begin
            saved_target <= pending.target;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/static_predictor.sv ====
// Static next pc guess: JAL and backward branches taken, all else pc+4.
// Purely combinational, the word must belong to the pc given with it.
`timescale 1ns/1ps
`default_nettype none

module static_predictor (
    input  fetch_pkg::pc_t            pc,
    input  logic [fetch_pkg::ilen-1:0] instr,
    output fetch_pkg::pc_t            pred_pc,
    output logic                      pred_taken
);

    fetch_pkg::instr_u word;
    fetch_pkg::pc_t    j_imm;     // sign extended jump offset
    fetch_pkg::pc_t    b_imm;     // sign extended branch offset
    fetch_pkg::pc_t    seq_pc;

    assign word = instr;

    assign j_imm = {
        {(fetch_pkg::xlen-21){word.j_fmt.imm20}},
        word.j_fmt.imm20,
        word.j_fmt.imm19_12,
        word.j_fmt.imm11,
        word.j_fmt.imm10_1,
        1'b0
    };

    assign b_imm = {
        {(fetch_pkg::xlen-13){word.b_fmt.imm12}},
        word.b_fmt.imm12,
        word.b_fmt.imm11,
        word.b_fmt.imm10_5,
        word.b_fmt.imm4_1,
        1'b0
    };

    assign seq_pc = pc + fetch_pkg::pc_t'(4);

    // opcode sits in the same bits for both views
    always_comb begin
        pred_pc    = seq_pc;
        pred_taken = 1'b0;
        case (word.j_fmt.opcode)
            fetch_pkg::op_jal: begin
                pred_pc    = pc + j_imm;
                pred_taken = 1'b1;
            end
            fetch_pkg::op_branch: begin
                if (word.b_fmt.imm12) begin    // negative offset, loop back
                    pred_pc    = pc + b_imm;
                    pred_taken = 1'b1;
                end
            end
            default: begin
                pred_pc    = seq_pc;
                pred_taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire
